//--- hdl/tmem_pkg.sv
`default_nettype none

package tmem_pkg;

    localparam int BUS_DATA_W = 32; // wishbone data width
    localparam int BUS_SEL_W  = 4;  // one select per byte lane
    localparam int BUS_ADR_W  = 16; // word address on the bus

    // master side of a classic wishbone cycle, 55 bits
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [BUS_SEL_W-1:0]  sel;
        logic [BUS_ADR_W-1:0]  adr; // word address
        logic [BUS_DATA_W-1:0] dat; // write data
    } wb_req_t;

    // slave side, 34 bits
    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [BUS_DATA_W-1:0] dat; // read data, valid with ack
    } wb_rsp_t;

    // one access per cycle into the tiled memory, fixed one-cycle read latency
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [BUS_SEL_W-1:0]  be;
        logic [BUS_ADR_W-1:0]  addr;  // low ADDR_W bits used
        logic [BUS_DATA_W-1:0] wdata;
    } ram_acc_t;

endpackage

`default_nettype wire

//--- hdl/tile_ram.sv
`timescale 1ns/100ps
`default_nettype none

// single block ram tile, byte-lane writes, registered read
module tile_ram #(
    parameter int TILE_ADDR_W = 11 // words per tile = 2**TILE_ADDR_W
) (
    input  wire                               clk,
    input  wire                               en,    // gated by the tile decoder
    input  wire                               we,
    input  wire  [tmem_pkg::BUS_SEL_W-1:0]    be,    // byte lane enables
    input  wire  [TILE_ADDR_W-1:0]            addr,  // word offset inside tile
    input  wire  [tmem_pkg::BUS_DATA_W-1:0]   wdata,
    output logic [tmem_pkg::BUS_DATA_W-1:0]   rdata  // valid one cycle after read
);

    import tmem_pkg::*;

    localparam int DEPTH  = 2 ** TILE_ADDR_W;
    localparam int LANE_W = BUS_DATA_W / BUS_SEL_W; // 8 bit lanes

    // storage, maps onto one bram
    logic [BUS_DATA_W-1:0] mem [DEPTH];

    // write side
    // each enabled lane is written on its own so the tool can infer
    // byte write enables on the bram primitive
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int lane = 0; lane < BUS_SEL_W; lane++) begin
                if (be[lane]) begin
                    mem[addr][lane*LANE_W +: LANE_W] <= wdata[lane*LANE_W +: LANE_W];
                end
            end
        end
    end

    // read side
    // output register only loads on a read, so the word holds
    // through following writes and idle cycles
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr]; // one cycle latency
        end
    end

    // a tile never sees a read and a write in the same cycle
    // since en/we come from one request; no collision handling needed

    // lanes must divide the word evenly
    if (BUS_DATA_W % BUS_SEL_W != 0) begin : g_lane_check
        $error("tile_ram: data width not a multiple of byte selects");
    end

    // depth sanity, a zero width tile makes no sense
    if (TILE_ADDR_W < 1) begin : g_depth_check
        $error("tile_ram: TILE_ADDR_W must be at least 1");
    end

endmodule

`default_nettype wire

//--- hdl/tiled_ram.sv
`timescale 1ns/100ps
`default_nettype none

// memory of 2**ADDR_W words built from equal tiles
// upper address bits pick the tile, lower bits index inside it
module tiled_ram #(
    parameter int ADDR_W      = 13, // total word address width
    parameter int TILE_ADDR_W = 11  // word address width of one tile
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  tmem_pkg::ram_acc_t          ram_acc, // one access per cycle
    output logic [tmem_pkg::BUS_DATA_W-1:0]   rdata    // word read one cycle ago
);

    import tmem_pkg::*;

    // tile count derived here only
    localparam int IDX_W   = ADDR_W - TILE_ADDR_W;     // tile index bits
    localparam int N_TILES = 2 ** IDX_W;
    localparam int SEL_W   = (IDX_W > 0) ? IDX_W : 1;  // keep a real vector for 1 tile

    logic [SEL_W-1:0]       tile_idx;   // tile addressed this cycle
    logic [TILE_ADDR_W-1:0] tile_off;   // word inside that tile
    logic [N_TILES-1:0]     tile_en;    // one-hot decoder output
    logic [SEL_W-1:0]       rd_sel_q;   // tile of the last read
    logic [BUS_DATA_W-1:0]  tile_rdata [N_TILES];

    // address split
    assign tile_idx = SEL_W'(ram_acc.addr[ADDR_W-1:0] >> TILE_ADDR_W);
    assign tile_off = ram_acc.addr[TILE_ADDR_W-1:0];

    // decoder, nothing selected when idle
    always_comb begin
        tile_en = '0;
        if (ram_acc.en) begin
            tile_en[tile_idx] = 1'b1;
        end
    end

    // tiles
    for (genvar t = 0; t < N_TILES; t++) begin : g_tile
        tile_ram #(
            .TILE_ADDR_W (TILE_ADDR_W)
        ) tile_ram_i (
            .clk   (clk),
            .en    (tile_en[t]),   // we only reaches the chosen tile through en
            .we    (ram_acc.we),
            .be    (ram_acc.be),
            .addr  (tile_off),
            .wdata (ram_acc.wdata),
            .rdata (tile_rdata[t])
        );
    end

    // read select register
    // loads on reads only, so it stays in step with the tile output
    // registers, which also only load on reads
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_sel_q <= '0;
        end else if (ram_acc.en && !ram_acc.we) begin
            rd_sel_q <= tile_idx; // lines up with bram latency
        end
    end

    // output mux
    always_comb begin
        rdata = tile_rdata[rd_sel_q];
    end

    // at most one tile active per cycle
    a_tile_en_onehot0 : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(tile_en)
    ) else $error("tiled_ram: more than one tile enabled");

    // address split must fit the memory
    if (TILE_ADDR_W > ADDR_W) begin : g_cfg_check
        $error("tiled_ram: TILE_ADDR_W exceeds ADDR_W");
    end

    // memory address must fit on the bus
    if (ADDR_W > BUS_ADR_W) begin : g_bus_check
        $error("tiled_ram: ADDR_W wider than the bus address");
    end

endmodule

`default_nettype wire

//--- hdl/wb_mem_slave.sv
`timescale 1ns/100ps
`default_nettype none

// wishbone classic slave in front of the tiled memory
// one access per request, terminated one cycle later with ack or err
module wb_mem_slave #(
    parameter int ADDR_W = 13 // memory depth is 2**ADDR_W words
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  tmem_pkg::wb_req_t           wb_req,
    output tmem_pkg::wb_rsp_t                 wb_rsp,
    output tmem_pkg::ram_acc_t                ram_acc,
    input  wire  [tmem_pkg::BUS_DATA_W-1:0]   rdata    // from tiled ram
);

    import tmem_pkg::*;

    logic req_new;   // fresh request this cycle
    logic in_range;  // address below memory depth
    logic ack_q;
    logic err_q;

    // a request counts once, the termination cycle blocks a repeat
    assign req_new = wb_req.cyc && wb_req.stb && !(ack_q || err_q);

    // any address bit at or above ADDR_W set means out of range
    assign in_range = ((wb_req.adr >> ADDR_W) == '0);

    // ram access, straight from the bus this cycle
    always_comb begin
        ram_acc.en    = req_new && in_range; // no access for bad addresses
        ram_acc.we    = wb_req.we;
        ram_acc.be    = wb_req.sel;
        ram_acc.addr  = wb_req.adr;
        ram_acc.wdata = wb_req.dat;
    end

    // termination, high for exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req_new && in_range;
            err_q <= req_new && !in_range;
        end
    end

    // response
    // ram output is valid in the ack cycle, same latency as the ack register
    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.err = err_q;
        wb_rsp.dat = ack_q ? rdata : '0; // zero on err and when idle
    end

    // never both terminations
    a_ack_err_excl : assert property (
        @(posedge clk) disable iff (reset)
        !(ack_q && err_q)
    ) else $error("wb_mem_slave: ack and err together");

    // termination only answers a strobe seen one cycle before
    a_term_after_stb : assert property (
        @(posedge clk) disable iff (reset)
        (ack_q || err_q) |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("wb_mem_slave: termination without strobe");

    // every word reaching the memory lies below the configured depth
    a_no_bad_access : assert property (
        @(posedge clk) disable iff (reset)
        ram_acc.en |-> (int'(ram_acc.addr) < (1 << ADDR_W))
    ) else $error("wb_mem_slave: ram access out of range");

    // memory must be addressable from the bus
    if (ADDR_W > BUS_ADR_W) begin : g_adr_check
        $error("wb_mem_slave: ADDR_W wider than bus address");
    end

endmodule

`default_nettype wire

//--- hdl/tmem_top.sv
`timescale 1ns/100ps
`default_nettype none

// on-chip memory on a wishbone classic port
// default 8192 words in 4 tiles of 2048
module tmem_top #(
    parameter int ADDR_W      = 13, // word address width of the memory
    parameter int TILE_ADDR_W = 11  // word address width of one tile
) (
    input  wire                      clk,
    input  wire                      reset,   // sync, active high
    input  wire  tmem_pkg::wb_req_t  wb_req,
    output tmem_pkg::wb_rsp_t        wb_rsp
);

    import tmem_pkg::*;

    ram_acc_t              ram_acc; // slave to memory
    logic [BUS_DATA_W-1:0] rdata;   // memory to slave

    // bus front end
    // range check and termination live here
    wb_mem_slave #(
        .ADDR_W (ADDR_W)
    ) wb_mem_slave_i (
        .clk     (clk),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .ram_acc (ram_acc),
        .rdata   (rdata)
    );

    // tiled storage
    // tile count follows from the two widths
    tiled_ram #(
        .ADDR_W      (ADDR_W),
        .TILE_ADDR_W (TILE_ADDR_W)
    ) tiled_ram_i (
        .clk     (clk),
        .reset   (reset),
        .ram_acc (ram_acc),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_tmem_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tmem_top;

    import tmem_pkg::*;

    localparam int ADDR_W      = 13;                        // 8192 words
    localparam int TILE_ADDR_W = 11;                        // 2048 words per tile
    localparam int TILE_WORDS  = 2 ** TILE_ADDR_W;
    localparam int N_TILES     = 2 ** (ADDR_W - TILE_ADDR_W);
    localparam int TIMEOUT_CYC = 20;                        // per access

    localparam logic WR  = 1'b1;
    localparam logic RD  = 1'b0;
    localparam logic ACK = 1'b0;
    localparam logic ERR = 1'b1;

    // one row of the stimulus table
    typedef struct packed {
        logic                  we;
        logic [BUS_ADR_W-1:0]  adr;
        logic [BUS_SEL_W-1:0]  sel;
        logic [BUS_DATA_W-1:0] dat;
        logic                  exp_err; // err expected instead of ack
    } step_t;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    step_t steps [$];

    // shadow memory, a byte counts only once its known flag is set
    logic [BUS_DATA_W-1:0] shadow [2**ADDR_W];
    logic [BUS_SEL_W-1:0]  known  [2**ADDR_W];

    int seed        = 13;
    int term_errors = 0;
    int data_errors = 0;
    int timeouts    = 0;

    tmem_top #(
        .ADDR_W      (ADDR_W),
        .TILE_ADDR_W (TILE_ADDR_W)
    ) tmem_top_i (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // termination kind of one response
    task automatic check_term(input wb_rsp_t got, input logic exp_ack, input logic exp_err);
        if (got.ack !== exp_ack) begin
            $display("[ERROR] wb_rsp.ack got 0x%h expected 0x%h at %0t", got.ack, exp_ack, $time);
            term_errors++;
        end
        if (got.err !== exp_err) begin
            $display("[ERROR] wb_rsp.err got 0x%h expected 0x%h at %0t", got.err, exp_err, $time);
            term_errors++;
        end
    endtask

    // read word, only lanes flagged in lanes are compared
    task automatic check_data(input logic [BUS_DATA_W-1:0] got,
                              input logic [BUS_DATA_W-1:0] exp,
                              input logic [BUS_SEL_W-1:0]  lanes,
                              input logic [BUS_ADR_W-1:0]  adr);
        logic [BUS_DATA_W-1:0] mask;
        for (int b = 0; b < BUS_SEL_W; b++) begin
            mask[b*8 +: 8] = {8{lanes[b]}};
        end
        if ((got & mask) !== (exp & mask)) begin
            $display("[ERROR] wb_rsp.dat got 0x%h expected 0x%h (lanes 0x%h, adr 0x%h)",
                     got, exp, lanes, adr);
            data_errors++;
        end
    endtask

    task automatic add_step(input logic we, input logic [BUS_ADR_W-1:0] adr,
                            input logic [BUS_SEL_W-1:0] sel,
                            input logic [BUS_DATA_W-1:0] dat, input logic exp_err);
        step_t s;
        s.we      = we;
        s.adr     = adr;
        s.sel     = sel;
        s.dat     = dat;
        s.exp_err = exp_err;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [BUS_ADR_W-1:0]  adr;
        logic [BUS_DATA_W-1:0] dat;
        int                    offs [3];
        offs = '{0, TILE_WORDS - 1, TILE_WORDS / 2}; // first, last, middle
        // full words through every tile
        for (int t = 0; t < N_TILES; t++) begin
            for (int i = 0; i < 3; i++) begin
                adr = BUS_ADR_W'(t * TILE_WORDS + offs[i]);
                dat = $random(seed);
                add_step(WR, adr, 4'hf, dat, ACK);
                add_step(RD, adr, 4'hf, '0, ACK);
            end
        end
        // byte lanes over a known word
        add_step(WR, 16'h0100, 4'hf, 32'h1122_3344, ACK);
        add_step(WR, 16'h0100, 4'h1, 32'hffff_ffa5, ACK);   // lane 0 only
        add_step(RD, 16'h0100, 4'hf, '0, ACK);
        add_step(WR, 16'h0100, 4'ha, 32'hdead_beef, ACK);   // lanes 1 and 3
        add_step(RD, 16'h0100, 4'hf, '0, ACK);
        add_step(WR, 16'h0100, 4'h6, 32'h5a5a_5a5a, ACK);
        add_step(WR, 16'h0100, 4'h0, 32'hffff_ffff, ACK);   // no lane, no change
        add_step(RD, 16'h0100, 4'hf, '0, ACK);
        add_step(WR, 16'h1a00, 4'h4, 32'h0077_0000, ACK);   // fresh word, lane 2 known
        add_step(RD, 16'h1a00, 4'hf, '0, ACK);
        // same offset in each tile
        add_step(WR, 16'h0055, 4'hf, 32'ha0a0_0055, ACK);
        add_step(WR, 16'h0855, 4'hf, 32'hb1b1_0855, ACK);
        add_step(WR, 16'h1055, 4'hf, 32'hc2c2_1055, ACK);
        add_step(WR, 16'h1855, 4'hf, 32'hd3d3_1855, ACK);
        add_step(RD, 16'h0055, 4'hf, '0, ACK);              // alternate tiles
        add_step(RD, 16'h1855, 4'hf, '0, ACK);
        add_step(RD, 16'h0855, 4'hf, '0, ACK);
        add_step(RD, 16'h1055, 4'hf, '0, ACK);
        add_step(RD, 16'h0055, 4'hf, '0, ACK);
        add_step(RD, 16'h1855, 4'hf, '0, ACK);
        // beyond the depth, low bits alias stored words
        add_step(WR, 16'h2055, 4'hf, 32'hbad0_0001, ERR);
        add_step(WR, 16'h2000, 4'hf, 32'hbad0_0002, ERR);
        add_step(WR, 16'hffff, 4'hf, 32'hbad0_0003, ERR);
        add_step(RD, 16'h4100, 4'hf, '0, ERR);
        add_step(RD, 16'h0055, 4'hf, '0, ACK);
        add_step(RD, 16'h0000, 4'hf, '0, ACK);
        add_step(RD, 16'h1fff, 4'hf, '0, ACK);
        add_step(RD, 16'h0100, 4'hf, '0, ACK);
    endtask

    // one classic cycle, request on a falling edge, answer one cycle later
    task automatic apply_step(input step_t s);
        int                    cycles;
        logic [BUS_DATA_W-1:0] exp_dat;
        logic [BUS_SEL_W-1:0]  exp_lanes;
        logic [ADDR_W-1:0]     idx;
        idx       = s.adr[ADDR_W-1:0];
        exp_dat   = s.exp_err ? '0 : shadow[idx];
        exp_lanes = s.exp_err ? '1 : known[idx];   // err carries all-zero data
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = s.we;
        wb_req.sel = s.sel;
        wb_req.adr = s.adr;
        wb_req.dat = s.dat;
        cycles = 0;
        do begin
            @(negedge clk);   // outputs settled since the rising edge
            cycles++;
        end while (!(wb_rsp.ack || wb_rsp.err) && cycles < TIMEOUT_CYC);
        if (!(wb_rsp.ack || wb_rsp.err)) begin
            $display("no termination for adr 0x%h within %0d cycles", s.adr, TIMEOUT_CYC);
            timeouts++;
        end else begin
            if (cycles != 1) begin
                $display("access at adr 0x%h terminated after %0d cycles instead of 1",
                         s.adr, cycles);
                term_errors++;
            end
            check_term(wb_rsp, !s.exp_err, s.exp_err);
            if (!s.we) begin
                check_data(wb_rsp.dat, exp_dat, exp_lanes, s.adr);
            end
            if (s.we && !s.exp_err) begin
                for (int b = 0; b < BUS_SEL_W; b++) begin
                    if (s.sel[b]) begin
                        shadow[idx][b*8 +: 8] = s.dat[b*8 +: 8];
                        known[idx][b]         = 1'b1;
                    end
                end
            end
        end
        wb_req = '0; // drop cyc and stb for a cycle
    endtask

    initial begin
        reset  = 1'b1;
        wb_req = '0;
        foreach (known[i]) begin
            known[i] = '0;   // nothing written yet
        end
        build_table();
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // quiet bus after reset
        repeat (8) begin
            @(negedge clk);
            check_term(wb_rsp, 1'b0, 1'b0);
        end

        for (int i = 0; i < steps.size() && timeouts == 0; i++) begin
            apply_step(steps[i]);
        end

        $display("errors: termination %0d, data %0d, timeouts %0d over %0d steps",
                 term_errors, data_errors, timeouts, steps.size());
        if (term_errors == 0 && data_errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/tmem_pkg.sv
hdl/tile_ram.sv
hdl/tiled_ram.sv
hdl/wb_mem_slave.sv
hdl/tmem_top.sv
tb/tb_tmem_top.sv

//--- run.sh
#!/bin/sh
# build and run the tiled memory testbench with verilator
# the verdict is taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_tmem_top -o tb_sim \
    -f filelist.f \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "run.sh: build or simulation did not complete"; exit 1; }

grep -qx "=== PASS ===" sim.log \
    && { echo "run.sh: simulation passed"; exit 0; } \
    || { echo "run.sh: simulation failed"; exit 1; }
